//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_pipeline_cpu
FILELIST = pipeline_cpu_top.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = *** TEST FAILED ***

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  wire  [rv_pkg::word_width-1:0]     if_insn,
    input  wire                               if_valid,
    input  wire  [rv_pkg::word_width-1:0]     rd_data_0,
    input  wire  [rv_pkg::word_width-1:0]     rd_data_1,
    input  wire                               id_gpr_we,
    input  wire  [rv_pkg::gpr_addr_width-1:0] id_dst_addr,
    input  wire  [rv_pkg::word_width-1:0]     alu_out,
    input  wire                               ex_gpr_we,
    input  wire  [rv_pkg::gpr_addr_width-1:0] ex_dst_addr,
    input  wire  [rv_pkg::word_width-1:0]     ex_alu_out,
    output logic [rv_pkg::gpr_addr_width-1:0] rd_addr_0,
    output logic [rv_pkg::gpr_addr_width-1:0] rd_addr_1,
    output rv_pkg::alu_op_t                   alu_op,
    output logic [rv_pkg::word_width-1:0]     alu_in_0,
    output logic [rv_pkg::word_width-1:0]     alu_in_1,
    output logic [rv_pkg::gpr_addr_width-1:0] dst_addr,
    output logic                              gpr_we
);

    import rv_pkg::*;

    opcode_t                 opcode;
    logic [funct3_width-1:0] funct3;
    logic [funct7_width-1:0] funct7;
    logic                    f7_base;
    logic                    f7_alt;
    logic [word_width-1:0]   imm_i;
    logic [word_width-1:0]   imm_u;
    logic [word_width-1:0]   rs1_val;
    logic [word_width-1:0]   rs2_val;
    logic                    supported;

    // execute result wins over write-back and x0 is never forwarded
    function automatic logic [word_width-1:0] fwd_operand(
        input logic [gpr_addr_width-1:0] addr,
        input logic [word_width-1:0]     rf_data
    );
        logic [word_width-1:0] val;
        val = rf_data;
        if (addr != '0) begin
            if (id_gpr_we && (id_dst_addr == addr)) begin
                val = alu_out;
            end else if (ex_gpr_we && (ex_dst_addr == addr)) begin
                val = ex_alu_out;
            end
        end
        return val;
    endfunction

    assign opcode    = opcode_t'(if_insn[opcode_lsb +: opcode_width]);
    assign funct3    = if_insn[funct3_lsb +: funct3_width];
    assign funct7    = if_insn[funct7_lsb +: funct7_width];
    assign f7_base   = (funct7 == funct7_base);
    assign f7_alt    = (funct7 == funct7_alt);
    assign rd_addr_0 = if_insn[rs1_lsb +: gpr_addr_width];
    assign rd_addr_1 = if_insn[rs2_lsb +: gpr_addr_width];
    assign dst_addr  = if_insn[rd_lsb +: gpr_addr_width];

    assign imm_i = {{(word_width - imm_i_width){if_insn[word_width-1]}},
                    if_insn[imm_i_lsb +: imm_i_width]};
    assign imm_u = {if_insn[imm_u_lsb +: imm_u_width], {(word_width - imm_u_width){1'b0}}};

    always_comb begin
        rs1_val = fwd_operand(rd_addr_0, rd_data_0);
        rs2_val = fwd_operand(rd_addr_1, rd_data_1);
    end

    always_comb begin
        alu_op    = alu_add;
        alu_in_0  = rs1_val;
        alu_in_1  = rs2_val;
        supported = 1'b0;
        case (opcode)
            op_reg: begin
                case (funct3)
                    3'b000: begin
                        alu_op    = f7_alt ? alu_sub : alu_add;
                        supported = f7_base || f7_alt;
                    end
                    3'b001: begin
                        alu_op    = alu_sll;
                        supported = f7_base;
                    end
                    3'b010: begin
                        alu_op    = alu_slt;
                        supported = f7_base;
                    end
                    3'b011: begin
                        alu_op    = alu_sltu;
                        supported = f7_base;
                    end
                    3'b100: begin
                        alu_op    = alu_xor;
                        supported = f7_base;
                    end
                    3'b101: begin
                        alu_op    = f7_alt ? alu_sra : alu_srl;
                        supported = f7_base || f7_alt;
                    end
                    3'b110: begin
                        alu_op    = alu_or;
                        supported = f7_base;
                    end
                    3'b111: begin
                        alu_op    = alu_and;
                        supported = f7_base;
                    end
                endcase
            end
            op_imm: begin
                alu_in_1  = imm_i;
                supported = 1'b1;
                case (funct3)
                    3'b000: alu_op = alu_add;
                    3'b010: alu_op = alu_slt;
                    3'b011: alu_op = alu_sltu;
                    3'b100: alu_op = alu_xor;
                    3'b110: alu_op = alu_or;
                    3'b111: alu_op = alu_and;
                    3'b001: begin
                        alu_op    = alu_sll;
                        supported = f7_base;
                    end
                    3'b101: begin
                        // shamt rides in the low immediate bits
                        alu_op    = f7_alt ? alu_sra : alu_srl;
                        supported = f7_base || f7_alt;
                    end
                endcase
            end
            op_lui: begin
                alu_op    = alu_pass1;
                alu_in_0  = '0;
                alu_in_1  = imm_u;
                supported = 1'b1;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    // bubbles, unknown encodings and rd == x0 write nothing
    assign gpr_we = if_valid && supported && (dst_addr != '0);

endmodule

`default_nettype wire

//--- hw/ex_stage.sv
`timescale 1ns/100ps
`default_nettype none

module ex_stage (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               cpu_en,
    input  wire  rv_pkg::alu_op_t             alu_op,
    input  wire  [rv_pkg::word_width-1:0]     alu_in_0,
    input  wire  [rv_pkg::word_width-1:0]     alu_in_1,
    input  wire  [rv_pkg::gpr_addr_width-1:0] dst_addr,
    input  wire                               gpr_we,
    output logic                              id_gpr_we,
    output logic [rv_pkg::gpr_addr_width-1:0] id_dst_addr,
    output logic [rv_pkg::word_width-1:0]     alu_out,
    output logic                              ex_gpr_we,
    output logic [rv_pkg::gpr_addr_width-1:0] ex_dst_addr,
    output logic [rv_pkg::word_width-1:0]     ex_alu_out
);

    import rv_pkg::*;

    alu_op_t                id_alu_op;
    logic [word_width-1:0]  id_alu_in_0;
    logic [word_width-1:0]  id_alu_in_1;
    logic [shamt_width-1:0] shamt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_gpr_we <= 1'b0;
            ex_gpr_we <= 1'b0;
        end else if (cpu_en) begin
            id_gpr_we <= gpr_we;
            ex_gpr_we <= id_gpr_we;
        end
    end

    // decode/execute and execute/write-back payload
    always_ff @(posedge clk) begin
        if (cpu_en) begin
            id_alu_op   <= alu_op;
            id_alu_in_0 <= alu_in_0;
            id_alu_in_1 <= alu_in_1;
            id_dst_addr <= dst_addr;
            ex_dst_addr <= id_dst_addr;
            ex_alu_out  <= alu_out;
        end
    end

    assign shamt = id_alu_in_1[shamt_width-1:0];

    always_comb begin
        alu_out = '0;
        case (id_alu_op)
            alu_add:   alu_out = id_alu_in_0 + id_alu_in_1;
            alu_sub:   alu_out = id_alu_in_0 - id_alu_in_1;
            alu_and:   alu_out = id_alu_in_0 & id_alu_in_1;
            alu_or:    alu_out = id_alu_in_0 | id_alu_in_1;
            alu_xor:   alu_out = id_alu_in_0 ^ id_alu_in_1;
            alu_sll:   alu_out = id_alu_in_0 << shamt;
            alu_srl:   alu_out = id_alu_in_0 >> shamt;
            alu_sra:   alu_out = $signed(id_alu_in_0) >>> shamt;
            alu_slt:   alu_out[0] = $signed(id_alu_in_0) < $signed(id_alu_in_1);
            alu_sltu:  alu_out[0] = id_alu_in_0 < id_alu_in_1;
            alu_pass1: alu_out = id_alu_in_1;
            default:   alu_out = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            cpu_en,
    input  wire  [rv_pkg::word_width-1:0]  insn,
    output logic [rv_pkg::pc_width-1:0]    pc,
    output logic [rv_pkg::pc_width-1:0]    if_pc,
    output logic [rv_pkg::word_width-1:0]  if_insn,
    output logic                           if_valid
);

    import rv_pkg::*;

    // program counter freezes with the rest of the core
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (cpu_en) begin
            pc       <= pc + pc_width'(pc_step);
            if_valid <= 1'b1;
        end
    end

    // fetch stage register
    always_ff @(posedge clk) begin
        if (cpu_en) begin
            if_pc   <= pc;
            if_insn <= insn;
        end
    end

endmodule

`default_nettype wire

//--- hw/gpr.sv
`timescale 1ns/100ps
`default_nettype none

module gpr (
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire                               we,
    input  wire  [rv_pkg::gpr_addr_width-1:0] wr_addr,
    input  wire  [rv_pkg::word_width-1:0]     wr_data,
    input  wire  [rv_pkg::gpr_addr_width-1:0] rd_addr_0,
    input  wire  [rv_pkg::gpr_addr_width-1:0] rd_addr_1,
    output logic [rv_pkg::word_width-1:0]     rd_data_0,
    output logic [rv_pkg::word_width-1:0]     rd_data_1
);

    import rv_pkg::*;

    logic [word_width-1:0] regs [2**gpr_addr_width];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**gpr_addr_width; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 always reads zero
    assign rd_data_0 = (rd_addr_0 == '0) ? '0 : regs[rd_addr_0];
    assign rd_data_1 = (rd_addr_1 == '0) ? '0 : regs[rd_addr_1];

endmodule

`default_nettype wire

//--- hw/pipeline_cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_cpu_top (
    input  wire                               cpu_en,
    input  wire                               clk,
    input  wire                               arst_n,
    input  wire  [rv_pkg::word_width-1:0]     insn,
    output logic [rv_pkg::pc_width-1:0]       pc,
    output logic                              retire_valid,
    output logic [rv_pkg::gpr_addr_width-1:0] retire_rd,
    output logic [rv_pkg::word_width-1:0]     retire_data
);

    import rv_pkg::*;

    logic [word_width-1:0]     if_insn;
    logic                      if_valid;
    logic [gpr_addr_width-1:0] rd_addr_0;
    logic [gpr_addr_width-1:0] rd_addr_1;
    logic [word_width-1:0]     rd_data_0;
    logic [word_width-1:0]     rd_data_1;
    alu_op_t                   alu_op;
    logic [word_width-1:0]     alu_in_0;
    logic [word_width-1:0]     alu_in_1;
    logic [gpr_addr_width-1:0] dst_addr;
    logic                      gpr_we;
    logic                      id_gpr_we;
    logic [gpr_addr_width-1:0] id_dst_addr;
    logic [word_width-1:0]     alu_out;
    logic                      ex_gpr_we;
    logic [gpr_addr_width-1:0] ex_dst_addr;
    logic [word_width-1:0]     ex_alu_out;
    logic                      wb_we;

    // write-back only happens on enabled edges
    assign wb_we        = ex_gpr_we & cpu_en;
    assign retire_valid = wb_we;
    assign retire_rd    = ex_dst_addr;
    assign retire_data  = ex_alu_out;

    fetch_unit u_fetch_unit (
        .clk         (clk         ),
        .arst_n      (arst_n      ),
        .cpu_en      (cpu_en      ),
        .insn        (insn        ),
        .pc          (pc          ),
        .if_pc       (            ),
        .if_insn     (if_insn     ),
        .if_valid    (if_valid    )
    );

    decoder u_decoder (
        .if_insn     (if_insn     ),
        .if_valid    (if_valid    ),
        .rd_data_0   (rd_data_0   ),
        .rd_data_1   (rd_data_1   ),
        .id_gpr_we   (id_gpr_we   ),
        .id_dst_addr (id_dst_addr ),
        .alu_out     (alu_out     ),
        .ex_gpr_we   (ex_gpr_we   ),
        .ex_dst_addr (ex_dst_addr ),
        .ex_alu_out  (ex_alu_out  ),
        .rd_addr_0   (rd_addr_0   ),
        .rd_addr_1   (rd_addr_1   ),
        .alu_op      (alu_op      ),
        .alu_in_0    (alu_in_0    ),
        .alu_in_1    (alu_in_1    ),
        .dst_addr    (dst_addr    ),
        .gpr_we      (gpr_we      )
    );

    gpr u_gpr (
        .clk         (clk         ),
        .arst_n      (arst_n      ),
        .we          (wb_we       ),
        .wr_addr     (ex_dst_addr ),
        .wr_data     (ex_alu_out  ),
        .rd_addr_0   (rd_addr_0   ),
        .rd_addr_1   (rd_addr_1   ),
        .rd_data_0   (rd_data_0   ),
        .rd_data_1   (rd_data_1   )
    );

    ex_stage u_ex_stage (
        .clk         (clk         ),
        .arst_n      (arst_n      ),
        .cpu_en      (cpu_en      ),
        .alu_op      (alu_op      ),
        .alu_in_0    (alu_in_0    ),
        .alu_in_1    (alu_in_1    ),
        .dst_addr    (dst_addr    ),
        .gpr_we      (gpr_we      ),
        .id_gpr_we   (id_gpr_we   ),
        .id_dst_addr (id_dst_addr ),
        .alu_out     (alu_out     ),
        .ex_gpr_we   (ex_gpr_we   ),
        .ex_dst_addr (ex_dst_addr ),
        .ex_alu_out  (ex_alu_out  )
    );

endmodule

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int word_width     = 32;
    localparam int pc_width       = 32;
    localparam int gpr_addr_width = 5;
    localparam int shamt_width    = 5;
    localparam int pc_step        = 4;

    // instruction field positions
    localparam int opcode_lsb   = 0;
    localparam int opcode_width = 7;
    localparam int rd_lsb       = 7;
    localparam int funct3_lsb   = 12;
    localparam int funct3_width = 3;
    localparam int rs1_lsb      = 15;
    localparam int rs2_lsb      = 20;
    localparam int funct7_lsb   = 25;
    localparam int funct7_width = 7;
    localparam int imm_i_lsb    = 20;
    localparam int imm_i_width  = 12;
    localparam int imm_u_lsb    = 12;
    localparam int imm_u_width  = 20;

    localparam logic [funct7_width-1:0] funct7_base = 7'b0000000;
    // sub and arithmetic shifts
    localparam logic [funct7_width-1:0] funct7_alt  = 7'b0100000;

    typedef enum logic [opcode_width-1:0] {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        op_lui = 7'b0110111
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add   = 4'd0,
        alu_sub   = 4'd1,
        alu_and   = 4'd2,
        alu_or    = 4'd3,
        alu_xor   = 4'd4,
        alu_sll   = 4'd5,
        alu_srl   = 4'd6,
        alu_sra   = 4'd7,
        alu_slt   = 4'd8,
        alu_sltu  = 4'd9,
        alu_pass1 = 4'd10
    } alu_op_t;

endpackage

`default_nettype wire

//--- pipeline_cpu_top.f
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/gpr.sv
hw/ex_stage.sv
hw/pipeline_cpu_top.sv
sim/pipeline_cpu_asserts.sv
sim/tb_pipeline_cpu.sv

//--- sim/pipeline_cpu_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module pipeline_cpu_asserts (
    input wire                               clk,
    input wire                               arst_n,
    input wire                               cpu_en,
    input wire [rv_pkg::pc_width-1:0]        pc,
    input wire                               retire_valid,
    input wire [rv_pkg::gpr_addr_width-1:0]  retire_rd,
    input wire [rv_pkg::word_width-1:0]      retire_data,
    input wire                               ex_gpr_we
);

    // writes to x0 are dropped in decode
    no_x0_retire: assert property (@(posedge clk) disable iff (!arst_n)
        retire_valid |-> (retire_rd != '0))
        else $error("retire_valid high with retire_rd pointing at x0");

    pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // a pending write survives a frozen edge unchanged
    pending_write_held: assert property (@(posedge clk) disable iff (!arst_n)
        (!cpu_en && ex_gpr_we) |=>
            (ex_gpr_we && $stable(retire_rd) && $stable(retire_data)))
        else $error("pending write changed or vanished across an edge with cpu_en low");

endmodule

bind pipeline_cpu_top pipeline_cpu_asserts u_asserts (
    .clk          (clk         ),
    .arst_n       (arst_n      ),
    .cpu_en       (cpu_en      ),
    .pc           (pc          ),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd   ),
    .retire_data  (retire_data ),
    .ex_gpr_we    (ex_gpr_we   )
);

`default_nettype wire

//--- sim/tb_pipeline_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pipeline_cpu;

    import rv_pkg::*;

    localparam int n_prog      = 200;
    localparam int reset_len   = 16;
    localparam int cycle_limit = 2000;
    localparam int end_pc      = (n_prog + 4) * 4;

    logic                      clk;
    logic                      arst_n;
    logic                      cpu_en;
    logic [word_width-1:0]     insn;
    logic [pc_width-1:0]       pc;
    logic                      retire_valid;
    logic [gpr_addr_width-1:0] retire_rd;
    logic [word_width-1:0]     retire_data;

    logic [31:0] image [n_prog];
    logic        en_pattern [cycle_limit];
    logic [31:0] model_regs [32];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          drive_cycle;

    int          mismatch_count;
    int          check_errors;
    int          retire_count;
    int          en_edges;
    logic [31:0] prev_pc;
    logic        prev_en;
    logic        have_prev;

    pipeline_cpu_top dut0 (
        .cpu_en       (cpu_en      ),
        .clk          (clk         ),
        .arst_n       (arst_n      ),
        .insn         (insn        ),
        .pc           (pc          ),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd   ),
        .retire_data  (retire_data )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [4:0] pick_reg();
        // mostly x0..x7 so dependencies stay close together
        if ($urandom_range(0, 3) != 0) begin
            return 5'($urandom_range(0, 7));
        end
        return 5'($urandom);
    endfunction

    function automatic logic [2:0] funct3_of(input alu_op_t op);
        case (op)
            alu_add, alu_sub: return 3'b000;
            alu_sll:          return 3'b001;
            alu_slt:          return 3'b010;
            alu_sltu:         return 3'b011;
            alu_xor:          return 3'b100;
            alu_srl, alu_sra: return 3'b101;
            alu_or:           return 3'b110;
            default:          return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] random_insn();
        int         kind;
        alu_op_t    op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [6:0] f7;
        logic [11:0] imm;
        kind = $urandom_range(0, 99);
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        op   = alu_op_t'(4'($urandom_range(0, 9)));
        f7   = (op == alu_sub || op == alu_sra) ? 7'b0100000 : 7'b0000000;
        if (kind < 45) begin
            return {f7, rs2, rs1, funct3_of(op), rd, op_reg};
        end
        if (kind < 83) begin
            // no subi in the ISA
            if (op == alu_sub) begin
                op = alu_add;
            end
            imm = 12'($urandom);
            if (op == alu_sll || op == alu_srl || op == alu_sra) begin
                imm = {f7, imm[4:0]};
            end
            return {imm, rs1, funct3_of(op), rd, op_imm};
        end
        if (kind < 92) begin
            return {20'($urandom), rd, op_lui};
        end
        // unsupported load, branch and mul encodings
        case ($urandom_range(0, 2))
            0:       return {25'($urandom), 7'b0000011};
            1:       return {25'($urandom), 7'b1100011};
            default: return {7'b0000001, rs2, rs1, 3'($urandom), rd, op_reg};
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        r = '0;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = {31'b0, $signed(a) < $signed(b)};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // executes one instruction on the model registers and returns 1 if it writes
    function automatic logic ref_exec(input logic [31:0] word, output logic [4:0] rd,
                                      output logic [31:0] val);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        ok;
        opcode = word[6:0];
        rd     = word[11:7];
        f3     = word[14:12];
        f7     = word[31:25];
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        imm    = {{20{word[31]}}, word[31:20]};
        ok     = 1'b0;
        val    = '0;
        if (opcode == op_reg) begin
            ok  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            val = alu_ref(f3, f7[5], a, b);
        end else if (opcode == op_imm) begin
            ok = 1'b1;
            if (f3 == 3'b001) begin
                ok = (f7 == 7'h00);
            end else if (f3 == 3'b101) begin
                ok = (f7 == 7'h00) || (f7 == 7'h20);
            end
            val = alu_ref(f3, (f3 == 3'b101) && f7[5], a, imm);
        end else if (opcode == op_lui) begin
            ok  = 1'b1;
            val = {word[31:12], 12'b0};
        end
        if (ok && rd != 5'd0) begin
            model_regs[rd] = val;
        end
        return ok && (rd != 5'd0);
    endfunction

    // unsupported custom-0 words carrying the address fill the space past the image
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < n_prog) begin
            return image[idx];
        end
        return {addr[24:0] ^ addr[31:7], 7'b0001011};
    endfunction

    // all DUT inputs change 1 ns after the rising edge
    initial begin
        arst_n      = 1'b0;
        cpu_en      = 1'b0;
        insn        = '0;
        drive_cycle = 0;
        forever begin
            @(posedge clk);
            #1;
            drive_cycle++;
            if (drive_cycle == reset_len) begin
                arst_n = 1'b1;
            end else if (drive_cycle > reset_len && drive_cycle < cycle_limit) begin
                cpu_en = en_pattern[drive_cycle];
            end
            insn = fetch_word(pc);
        end
    end

    initial begin
        mismatch_count = 0;
        check_errors   = 0;
        retire_count   = 0;
        en_edges       = 0;
        prev_pc        = '0;
        prev_en        = 1'b0;
        have_prev      = 1'b0;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            if (!have_prev && pc !== '0) begin
                $display("FAIL %0t: pc after reset is %h, expected 0", $time, pc);
                mismatch_count++;
            end
            if (have_prev && pc !== (prev_en ? prev_pc + pc_width'(pc_step) : prev_pc)) begin
                $display("FAIL %0t: pc %h after pc %h with cpu_en %0b", $time, pc, prev_pc,
                         prev_en);
                mismatch_count++;
            end
            prev_pc   = pc;
            prev_en   = cpu_en;
            have_prev = 1'b1;
            if (retire_valid) begin
                if (!cpu_en) begin
                    $display("ERROR: a write retired at %0t while the core was frozen", $time);
                    check_errors++;
                end
                if (en_edges < 3) begin
                    $display("ERROR: a write retired at %0t after only %0d enabled edges",
                             $time, en_edges);
                    check_errors++;
                end
                if (retire_count >= exp_rd.size()) begin
                    $display("ERROR: extra write to x%0d retired at %0t", retire_rd, $time);
                    check_errors++;
                end else if (retire_rd !== exp_rd[retire_count] ||
                             retire_data !== exp_data[retire_count]) begin
                    $display("FAIL %0t: retire #%0d x%0d=%h, expected x%0d=%h", $time,
                             retire_count, retire_rd, retire_data, exp_rd[retire_count],
                             exp_data[retire_count]);
                    mismatch_count++;
                end
                retire_count++;
            end
            if (cpu_en) begin
                en_edges++;
            end
        end
    end

    initial begin
        logic [4:0]  rd;
        logic [31:0] val;
        logic        finished;
        logic        timed_out;
        int          end_errors;
        void'($urandom(32'h1bd8));
        finished   = 1'b0;
        timed_out  = 1'b0;
        end_errors = 0;
        for (int i = 0; i < n_prog; i++) begin
            image[i] = random_insn();
        end
        for (int i = 0; i < cycle_limit; i++) begin
            en_pattern[i] = ($urandom_range(0, 9) >= 2);
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < n_prog; i++) begin
            if (ref_exec(image[i], rd, val)) begin
                exp_rd.push_back(rd);
                exp_data.push_back(val);
            end
        end
        while (!finished && !timed_out) begin
            @(negedge clk);
            if (arst_n && pc >= end_pc) begin
                finished = 1'b1;
            end else if (drive_cycle >= cycle_limit) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("ERROR: timeout, program did not finish within %0d cycles", cycle_limit);
            end_errors++;
        end
        if (retire_count != exp_rd.size()) begin
            $display("ERROR: %0d writes retired but the program makes %0d", retire_count,
                     exp_rd.size());
            end_errors++;
        end
        $display("errors: %0d wrong values, %0d other; %0d of %0d writes retired",
                 mismatch_count, check_errors + end_errors, retire_count, exp_rd.size());
        if (mismatch_count + check_errors + end_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
